/* common/ctrlPkg.sv */
package ctrlPkg;

  // Instruction fields
  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;

  // Opcodes
  localparam opcodeT opRType = 6'h00;
  localparam opcodeT opJ     = 6'h02;
  localparam opcodeT opJal   = 6'h03;
  localparam opcodeT opBeq   = 6'h04;
  localparam opcodeT opBne   = 6'h05;
  localparam opcodeT opBle   = 6'h06;
  localparam opcodeT opBgt   = 6'h07;
  localparam opcodeT opAddi  = 6'h08;
  localparam opcodeT opAddiu = 6'h09;
  localparam opcodeT opSlti  = 6'h0A;
  localparam opcodeT opLb    = 6'h20;
  localparam opcodeT opLh    = 6'h21;
  localparam opcodeT opLw    = 6'h23;
  localparam opcodeT opSb    = 6'h28;
  localparam opcodeT opSh    = 6'h29;
  localparam opcodeT opSw    = 6'h2B;

  // Funct codes under R-type
  localparam functT fnJr  = 6'h08;
  localparam functT fnAdd = 6'h20;
  localparam functT fnSub = 6'h22;
  localparam functT fnAnd = 6'h24;
  localparam functT fnSlt = 6'h2A;

  // Datapath select codes
  typedef logic [2:0] aluOpT;
  typedef logic [2:0] addrSelT;
  typedef logic [2:0] pcSourceT;
  typedef logic [2:0] memToRegT;
  typedef logic [1:0] regDstT;
  typedef logic [1:0] aluSrcBT;
  typedef logic [1:0] lsSizeT;
  typedef logic [1:0] branchCondT;

  localparam aluOpT aluPass = 3'b000;
  localparam aluOpT aluAdd  = 3'b001;
  localparam aluOpT aluSub  = 3'b010;
  localparam aluOpT aluAnd  = 3'b011;
  localparam aluOpT aluSlt  = 3'b111;

  localparam addrSelT addrPc          = 3'b000;
  localparam addrSelT addrAluOut      = 3'b001;
  localparam addrSelT addrVecInvalid  = 3'b010;
  localparam addrSelT addrVecOverflow = 3'b011;

  localparam pcSourceT pcSrcPlus4  = 3'b000;
  localparam pcSourceT pcSrcJump   = 3'b001;
  localparam pcSourceT pcSrcVector = 3'b010;
  localparam pcSourceT pcSrcAluOut = 3'b011;

  localparam memToRegT memToRegAlu = 3'b000;
  localparam memToRegT memToRegMem = 3'b101;

  localparam regDstT regDstRt  = 2'b00;
  localparam regDstT regDstRd  = 2'b01;
  localparam regDstT regDstR31 = 2'b11;

  localparam aluSrcBT srcBReg    = 2'b00;
  localparam aluSrcBT srcBImm    = 2'b01;
  localparam aluSrcBT srcBOffset = 2'b10;
  localparam aluSrcBT srcBFour   = 2'b11;

  localparam lsSizeT lsNone = 2'b00;
  localparam lsSizeT lsByte = 2'b01;
  localparam lsSizeT lsHalf = 2'b10;
  localparam lsSizeT lsWord = 2'b11;

  localparam branchCondT condBne = 2'b00;
  localparam branchCondT condBeq = 2'b01;
  localparam branchCondT condBle = 2'b10;
  localparam branchCondT condBgt = 2'b11;

  typedef enum logic [3:0] {
    clsAlu, clsSlt, clsLoad, clsStore, clsBranch,
    clsJump, clsJal, clsJr, clsInvalid
  } instrClassE;

  typedef enum logic [3:0] {
    phIdle, phFetch, phWait, phDecode, phExec, phWrite, phMemAddr, phMemRead,
    phMemWrite, phBranch, phLinkCalc, phLinkWrite, phJump, phTrapSave,
    phVecInvalid, phVecOverflow
  } phaseE;

endpackage

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  ctrlPkg::opcodeT     opcode,
  input  ctrlPkg::functT      funct,
  output ctrlPkg::instrClassE instrClass,
  output logic                trapOnOvf,
  output ctrlPkg::aluOpT      aluOp,
  output logic                usesImm,
  output ctrlPkg::lsSizeT     lsSize,
  output ctrlPkg::branchCondT branchCond
);

  import ctrlPkg::*;

  always_comb begin
    instrClass = clsInvalid;
    trapOnOvf  = 1'b0;
    aluOp      = aluPass;
    usesImm    = 1'b0;
    lsSize     = lsNone;
    branchCond = condBne;

    case (opcode)
      opRType: begin
        case (funct)
          fnAdd: begin
            instrClass = clsAlu;
            aluOp      = aluAdd;
            trapOnOvf  = 1'b1;
          end
          fnSub: begin
            instrClass = clsAlu;
            aluOp      = aluSub;
            trapOnOvf  = 1'b1;
          end
          fnAnd: begin
            instrClass = clsAlu;
            aluOp      = aluAnd;
          end
          fnSlt: begin
            instrClass = clsSlt;
            aluOp      = aluSlt;
          end
          // rs goes through the ALU unchanged
          fnJr: instrClass = clsJr;
          default: instrClass = clsInvalid;
        endcase
      end
      opAddi: begin
        instrClass = clsAlu;
        aluOp      = aluAdd;
        usesImm    = 1'b1;
        trapOnOvf  = 1'b1;
      end
      opAddiu: begin
        instrClass = clsAlu;
        aluOp      = aluAdd;
        usesImm    = 1'b1;
      end
      opSlti: begin
        instrClass = clsSlt;
        aluOp      = aluSlt;
        usesImm    = 1'b1;
      end
      opLb, opLh, opLw: begin
        instrClass = clsLoad;
        aluOp      = aluAdd;
        lsSize     = (opcode == opLb) ? lsByte : (opcode == opLh) ? lsHalf : lsWord;
      end
      opSb, opSh, opSw: begin
        instrClass = clsStore;
        aluOp      = aluAdd;
        lsSize     = (opcode == opSb) ? lsByte : (opcode == opSh) ? lsHalf : lsWord;
      end
      opBeq, opBne, opBle, opBgt: begin
        instrClass = clsBranch;
        aluOp      = aluSlt;
        case (opcode)
          opBeq:   branchCond = condBeq;
          opBle:   branchCond = condBle;
          opBgt:   branchCond = condBgt;
          default: branchCond = condBne;
        endcase
      end
      // Non-pass op marks these apart from jr in the jump phase
      opJ: begin
        instrClass = clsJump;
        aluOp      = aluAdd;
      end
      opJal: begin
        instrClass = clsJal;
        aluOp      = aluAdd;
      end
      default: instrClass = clsInvalid;
    endcase
  end

endmodule

/* rtl/phaseSequencer.sv */
`timescale 1ns/1ps

module phaseSequencer (
  input  logic                clk,
  input  logic                reset_in,
  input  ctrlPkg::instrClassE instrClass,
  input  logic                trapOnOvf,
  input  logic                ovf,
  output ctrlPkg::phaseE      phase
);

  import ctrlPkg::*;

  phaseE nextPhase;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= phIdle;
    end else begin
      phase <= nextPhase;
    end
  end

  always_comb begin
    nextPhase = phase;
    case (phase)
      phIdle:   nextPhase = phFetch;
      phFetch:  nextPhase = phWait;
      phWait:   nextPhase = phDecode;

      phDecode: begin
        case (instrClass)
          clsAlu, clsSlt, clsJr: nextPhase = phExec;
          clsLoad, clsStore:     nextPhase = phMemAddr;
          clsBranch:             nextPhase = phBranch;
          clsJump:               nextPhase = phJump;
          clsJal:                nextPhase = phLinkCalc;
          default:               nextPhase = phTrapSave;
        endcase
      end

      phExec: begin
        if (instrClass == clsJr) begin
          nextPhase = phJump;
        end else begin
          nextPhase = phWrite;
        end
      end

      // Overflow is only meaningful after the ALU result is written
      phWrite: begin
        if (ovf && trapOnOvf) begin
          nextPhase = phTrapSave;
        end else begin
          nextPhase = phFetch;
        end
      end

      phMemAddr: begin
        if (instrClass == clsLoad) begin
          nextPhase = phMemRead;
        end else begin
          nextPhase = phMemWrite;
        end
      end

      phMemRead:   nextPhase = phWrite;
      phMemWrite:  nextPhase = phFetch;
      phBranch:    nextPhase = phFetch;
      phLinkCalc:  nextPhase = phLinkWrite;
      phLinkWrite: nextPhase = phJump;
      phJump:      nextPhase = phFetch;

      phTrapSave: begin
        if (instrClass == clsInvalid) begin
          nextPhase = phVecInvalid;
        end else begin
          nextPhase = phVecOverflow;
        end
      end

      phVecInvalid:  nextPhase = phFetch;
      phVecOverflow: nextPhase = phFetch;
      default:       nextPhase = phIdle;
    endcase
  end

endmodule

/* rtl/controlEncoder.sv */
`timescale 1ns/1ps

module controlEncoder (
  input  ctrlPkg::phaseE      phase,
  input  ctrlPkg::aluOpT      aluOp,
  input  logic                usesImm,
  input  ctrlPkg::lsSizeT     lsSize,
  input  ctrlPkg::branchCondT branchCond,
  output logic                pcWrite,
  output logic                pcWriteCond,
  output logic                memRead,
  output logic                memWrite,
  output logic                irWrite,
  output logic                regWrite,
  output logic                aluSrcA,
  output logic                ltOut,
  output ctrlPkg::branchCondT condControl,
  output ctrlPkg::aluOpT      aluOpOut,
  output ctrlPkg::lsSizeT     lsSizeOut,
  output ctrlPkg::addrSelT    addrSel,
  output ctrlPkg::regDstT     regDst,
  output ctrlPkg::memToRegT   memToReg,
  output ctrlPkg::aluSrcBT    aluSrcB,
  output ctrlPkg::pcSourceT   pcSource
);

  import ctrlPkg::*;

  always_comb begin
    pcWrite     = 1'b0;
    pcWriteCond = 1'b0;
    memRead     = 1'b0;
    memWrite    = 1'b0;
    irWrite     = 1'b0;
    regWrite    = 1'b0;
    aluSrcA     = 1'b0;
    ltOut       = 1'b0;
    condControl = condBne;
    aluOpOut    = aluPass;
    lsSizeOut   = lsNone;
    addrSel     = addrPc;
    regDst      = regDstRt;
    memToReg    = memToRegAlu;
    aluSrcB     = srcBReg;
    pcSource    = pcSrcPlus4;

    case (phase)
      phFetch: begin
        memRead  = 1'b1;
        irWrite  = 1'b1;
        pcWrite  = 1'b1;
        addrSel  = addrPc;
        pcSource = pcSrcPlus4;
        aluSrcB  = srcBFour;
        aluOpOut = aluAdd;
      end

      // Branch target computed ahead of time
      phDecode: begin
        aluSrcB  = srcBOffset;
        aluOpOut = aluAdd;
      end

      phExec: begin
        aluSrcA  = 1'b1;
        aluOpOut = aluOp;
        aluSrcB  = usesImm ? srcBImm : srcBReg;
      end

      // Load, slt and plain ALU writes share this phase
      phWrite: begin
        regWrite = 1'b1;
        if (lsSize != lsNone) begin
          regDst    = regDstRt;
          memToReg  = memToRegMem;
          lsSizeOut = lsSize;
        end else begin
          regDst = usesImm ? regDstRt : regDstRd;
          ltOut  = (aluOp == aluSlt);
        end
      end

      phMemAddr: begin
        aluSrcA  = 1'b1;
        aluSrcB  = srcBImm;
        aluOpOut = aluAdd;
      end

      phMemRead: begin
        memRead   = 1'b1;
        addrSel   = addrAluOut;
        lsSizeOut = lsSize;
      end

      phMemWrite: begin
        memWrite  = 1'b1;
        addrSel   = addrAluOut;
        lsSizeOut = lsSize;
      end

      phBranch: begin
        pcWriteCond = 1'b1;
        aluSrcA     = 1'b1;
        aluOpOut    = aluSlt;
        pcSource    = pcSrcAluOut;
        condControl = branchCond;
      end

      // Return address is pc+4
      phLinkCalc: begin
        aluSrcB  = srcBFour;
        aluOpOut = aluAdd;
      end

      phLinkWrite: begin
        regWrite = 1'b1;
        regDst   = regDstR31;
      end

      phJump: begin
        pcWrite  = 1'b1;
        pcSource = (aluOp == aluPass) ? pcSrcAluOut : pcSrcJump;
      end

      phTrapSave: aluOpOut = aluPass;

      phVecInvalid: begin
        memRead  = 1'b1;
        pcWrite  = 1'b1;
        pcSource = pcSrcVector;
        addrSel  = addrVecInvalid;
      end

      phVecOverflow: begin
        memRead  = 1'b1;
        pcWrite  = 1'b1;
        pcSource = pcSrcVector;
        addrSel  = addrVecOverflow;
      end

      default: ;
    endcase
  end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
  input  logic                clk,
  input  logic                reset_in,
  input  ctrlPkg::opcodeT     opcode,
  input  ctrlPkg::functT      funct,
  input  logic                ovf,
  output logic                pcWrite,
  output logic                pcWriteCond,
  output logic                memRead,
  output logic                memWrite,
  output logic                irWrite,
  output logic                regWrite,
  output logic                aluSrcA,
  output logic                ltOut,
  output ctrlPkg::branchCondT condControl,
  output ctrlPkg::aluOpT      aluOpOut,
  output ctrlPkg::lsSizeT     lsSizeOut,
  output ctrlPkg::addrSelT    addrSel,
  output ctrlPkg::regDstT     regDst,
  output ctrlPkg::memToRegT   memToReg,
  output ctrlPkg::aluSrcBT    aluSrcB,
  output ctrlPkg::pcSourceT   pcSource
);

  import ctrlPkg::*;

  instrClassE instrClass;
  logic       trapOnOvf;
  aluOpT      aluOp;
  logic       usesImm;
  lsSizeT     lsSize;
  branchCondT branchCond;
  phaseE      phase;

  instrDecoder uDecoder (
    .opcode     (opcode),
    .funct      (funct),
    .instrClass (instrClass),
    .trapOnOvf  (trapOnOvf),
    .aluOp      (aluOp),
    .usesImm    (usesImm),
    .lsSize     (lsSize),
    .branchCond (branchCond)
  );

  phaseSequencer uSequencer (
    .clk        (clk),
    .reset_in   (reset_in),
    .instrClass (instrClass),
    .trapOnOvf  (trapOnOvf),
    .ovf        (ovf),
    .phase      (phase)
  );

  controlEncoder uEncoder (
    .phase       (phase),
    .aluOp       (aluOp),
    .usesImm     (usesImm),
    .lsSize      (lsSize),
    .branchCond  (branchCond),
    .pcWrite     (pcWrite),
    .pcWriteCond (pcWriteCond),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .irWrite     (irWrite),
    .regWrite    (regWrite),
    .aluSrcA     (aluSrcA),
    .ltOut       (ltOut),
    .condControl (condControl),
    .aluOpOut    (aluOpOut),
    .lsSizeOut   (lsSizeOut),
    .addrSel     (addrSel),
    .regDst      (regDst),
    .memToReg    (memToReg),
    .aluSrcB     (aluSrcB),
    .pcSource    (pcSource)
  );

endmodule

/* dv/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

  import ctrlPkg::*;

  localparam int numInstr = 400;
  localparam int cycleLimit = numInstr * 7 + 100;

  logic clk = 1'b0;
  logic reset_in;
  opcodeT opcode;
  functT funct;
  logic ovf;
  logic pcWrite, pcWriteCond, memRead, memWrite, irWrite, regWrite, aluSrcA, ltOut;
  branchCondT condControl;
  aluOpT aluOpOut;
  lsSizeT lsSizeOut;
  addrSelT addrSel;
  regDstT regDst;
  memToRegT memToReg;
  aluSrcBT aluSrcB;
  pcSourceT pcSource;

  // Instruction as chosen by the testbench
  instrClassE tClass = clsAlu;
  aluOpT tAluOp = aluPass;
  logic tImm = 1'b0;
  lsSizeT tSize = lsNone;
  branchCondT tCond = condBne;
  logic tTrap = 1'b0;
  string tName = "none";

  phaseE refPhase = phIdle;
  int cycles = 0;
  int sinceFetch = 0;
  int done = 0;
  int errCount = 0;
  int errAtStart = 0;
  int passCount = 0;
  int failCount = 0;
  logic haveInstr = 1'b0;

  logic ePcWrite, ePcWriteCond, eMemRead, eMemWrite, eIrWrite, eRegWrite, eAluSrcA, eLtOut;
  branchCondT eCond;
  aluOpT eAluOp;
  lsSizeT eSize;
  addrSelT eAddr;
  regDstT eRegDst;
  memToRegT eMemToReg;
  aluSrcBT eSrcB;
  pcSourceT ePcSrc;
  logic [27:0] actBus;
  logic [27:0] expBus;

  controlUnit dut (.*);

  always #2 clk = ~clk;

  assign actBus = {pcWrite, pcWriteCond, memRead, memWrite, irWrite, regWrite, aluSrcA,
                   ltOut, condControl, aluOpOut, lsSizeOut, addrSel, regDst, memToReg,
                   aluSrcB, pcSource};
  assign expBus = {ePcWrite, ePcWriteCond, eMemRead, eMemWrite, eIrWrite, eRegWrite,
                   eAluSrcA, eLtOut, eCond, eAluOp, eSize, eAddr, eRegDst, eMemToReg,
                   eSrcB, ePcSrc};

  // Expected outputs per phase
  always_comb begin
    {ePcWrite, ePcWriteCond, eMemRead, eMemWrite, eIrWrite, eRegWrite, eAluSrcA} = '0;
    eLtOut = 1'b0;
    eCond = 2'b00;
    eAluOp = 3'b000;
    eSize = 2'b00;
    eAddr = 3'b000;
    eRegDst = 2'b00;
    eMemToReg = 3'b000;
    eSrcB = 2'b00;
    ePcSrc = 3'b000;
    case (refPhase)
      phFetch: begin
        {eMemRead, eIrWrite, ePcWrite} = 3'b111;
        eSrcB = 2'b11;
        eAluOp = 3'b001;
      end
      phDecode: begin
        eSrcB = 2'b10;
        eAluOp = 3'b001;
      end
      phExec: begin
        eAluSrcA = 1'b1;
        eAluOp = tAluOp;
        eSrcB = tImm ? 2'b01 : 2'b00;
      end
      phWrite: begin
        eRegWrite = 1'b1;
        if (tClass == clsLoad) begin
          eMemToReg = 3'b101;
          eSize = tSize;
        end else begin
          eRegDst = tImm ? 2'b00 : 2'b01;
          eLtOut = (tClass == clsSlt);
        end
      end
      phMemAddr: begin
        eAluSrcA = 1'b1;
        eSrcB = 2'b01;
        eAluOp = 3'b001;
      end
      phMemRead: begin
        eMemRead = 1'b1;
        eAddr = 3'b001;
        eSize = tSize;
      end
      phMemWrite: begin
        eMemWrite = 1'b1;
        eAddr = 3'b001;
        eSize = tSize;
      end
      phBranch: begin
        ePcWriteCond = 1'b1;
        eAluSrcA = 1'b1;
        eAluOp = 3'b111;
        ePcSrc = 3'b011;
        eCond = tCond;
      end
      phLinkCalc: begin
        eSrcB = 2'b11;
        eAluOp = 3'b001;
      end
      phLinkWrite: begin
        eRegWrite = 1'b1;
        eRegDst = 2'b11;
      end
      phJump: begin
        ePcWrite = 1'b1;
        ePcSrc = (tClass == clsJr) ? 3'b011 : 3'b001;
      end
      phVecInvalid, phVecOverflow: begin
        {eMemRead, ePcWrite} = 2'b11;
        ePcSrc = 3'b010;
        eAddr = (refPhase == phVecInvalid) ? 3'b010 : 3'b011;
      end
      default: ;
    endcase
  end

  // Reference phase model
  always @(posedge clk) begin
    if (reset_in) begin
      refPhase <= phIdle;
    end else begin
      case (refPhase)
        phIdle: refPhase <= phFetch;
        phFetch: refPhase <= phWait;
        phWait: refPhase <= phDecode;
        phDecode: begin
          case (tClass)
            clsAlu, clsSlt, clsJr: refPhase <= phExec;
            clsLoad, clsStore: refPhase <= phMemAddr;
            clsBranch: refPhase <= phBranch;
            clsJump: refPhase <= phJump;
            clsJal: refPhase <= phLinkCalc;
            default: refPhase <= phTrapSave;
          endcase
        end
        phExec: refPhase <= (tClass == clsJr) ? phJump : phWrite;
        phWrite: refPhase <= (tTrap && ovf) ? phTrapSave : phFetch;
        phMemAddr: refPhase <= (tClass == clsLoad) ? phMemRead : phMemWrite;
        phMemRead: refPhase <= phWrite;
        phLinkCalc: refPhase <= phLinkWrite;
        phLinkWrite: refPhase <= phJump;
        phTrapSave: refPhase <= (tClass == clsInvalid) ? phVecInvalid : phVecOverflow;
        default: refPhase <= phFetch;
      endcase
    end
  end

  outputsMatch: assert property (@(posedge clk) disable iff (cycles < 2) actBus == expBus)
    else begin
      errCount++;
      $display("ERROR %0t: %s outputs %h, expected %h", $time, tName,
               $sampled(actBus), $sampled(expBus));
    end

  function automatic int pathLength(instrClassE cls, logic trapTaken);
    case (cls)
      clsAlu, clsSlt: return trapTaken ? 7 : 5;
      clsLoad, clsJal: return 6;
      clsBranch, clsJump: return 4;
      default: return 5;
    endcase
  endfunction

  task automatic chooseInstr(input int pick);
    opcodeT op;
    functT fn;
    op = opRType;
    fn = 6'h00;
    tImm <= 1'b0;
    tSize <= lsNone;
    tCond <= condBne;
    tTrap <= 1'b0;
    tAluOp <= 3'b001;
    case (pick)
      0: begin
        fn = fnAdd;
        tClass <= clsAlu;
        tTrap <= 1'b1;
        tName <= "add";
      end
      1: begin
        fn = fnAnd;
        tClass <= clsAlu;
        tAluOp <= 3'b011;
        tName <= "and";
      end
      2: begin
        fn = fnSub;
        tClass <= clsAlu;
        tAluOp <= 3'b010;
        tTrap <= 1'b1;
        tName <= "sub";
      end
      3: begin
        fn = fnSlt;
        tClass <= clsSlt;
        tAluOp <= 3'b111;
        tName <= "slt";
      end
      4: begin
        fn = fnJr;
        tClass <= clsJr;
        tAluOp <= 3'b000;
        tName <= "jr";
      end
      5: begin
        op = opAddi;
        tClass <= clsAlu;
        tImm <= 1'b1;
        tTrap <= 1'b1;
        tName <= "addi";
      end
      6: begin
        op = opAddiu;
        tClass <= clsAlu;
        tImm <= 1'b1;
        tName <= "addiu";
      end
      7: begin
        op = opSlti;
        tClass <= clsSlt;
        tImm <= 1'b1;
        tAluOp <= 3'b111;
        tName <= "slti";
      end
      8: begin
        op = opLb;
        tClass <= clsLoad;
        tSize <= 2'b01;
        tName <= "lb";
      end
      9: begin
        op = opLh;
        tClass <= clsLoad;
        tSize <= 2'b10;
        tName <= "lh";
      end
      10: begin
        op = opLw;
        tClass <= clsLoad;
        tSize <= 2'b11;
        tName <= "lw";
      end
      11: begin
        op = opSb;
        tClass <= clsStore;
        tSize <= 2'b01;
        tName <= "sb";
      end
      12: begin
        op = opSh;
        tClass <= clsStore;
        tSize <= 2'b10;
        tName <= "sh";
      end
      13: begin
        op = opSw;
        tClass <= clsStore;
        tSize <= 2'b11;
        tName <= "sw";
      end
      14: begin
        op = opBeq;
        tClass <= clsBranch;
        tCond <= 2'b01;
        tName <= "beq";
      end
      15: begin
        op = opBne;
        tClass <= clsBranch;
        tCond <= 2'b00;
        tName <= "bne";
      end
      16: begin
        op = opBle;
        tClass <= clsBranch;
        tCond <= 2'b10;
        tName <= "ble";
      end
      17: begin
        op = opBgt;
        tClass <= clsBranch;
        tCond <= 2'b11;
        tName <= "bgt";
      end
      18: begin
        op = opJ;
        tClass <= clsJump;
        tName <= "j";
      end
      19: begin
        op = opJal;
        tClass <= clsJal;
        tName <= "jal";
      end
      default: begin
        op = 6'h3F;
        tClass <= clsInvalid;
        tName <= "invalid";
      end
    endcase
    opcode <= op;
    funct <= fn;
    ovf <= 1'($urandom % 2);
  endtask

  // One test per instruction, closed at the next fetch
  always @(posedge clk) begin
    if (cycles == 0) begin
      void'($urandom(41));
    end
    sinceFetch <= irWrite ? 1 : sinceFetch + 1;
    if (irWrite && !reset_in) begin
      if (haveInstr) begin
        instrLength: assert (sinceFetch == pathLength(tClass, tTrap && ovf))
          else begin
            errCount++;
            $display("ERROR %0t: %s took %0d cycles", $time, tName, sinceFetch);
          end
        if (errCount == errAtStart) begin
          passCount++;
          $display("test %0d %s ovf=%0b: ok", done, tName, ovf);
        end else begin
          failCount++;
          $display("test %0d %s ovf=%0b: failed", done, tName, ovf);
        end
        done++;
      end
      errAtStart = errCount;
      if (done == numInstr) begin
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
          $display("STATUS: PASS");
        end else begin
          $display("STATUS: FAIL");
        end
        $finish;
      end else begin
        haveInstr <= 1'b1;
        chooseInstr(int'($urandom % 22));
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    reset_in = 1'b1;
    opcode = 6'h00;
    funct = 6'h00;
    ovf = 1'b0;
    repeat (5) @(posedge clk);
    reset_in <= 1'b0;
  end

endmodule

/* filelist.f */
common/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/phaseSequencer.sv
rtl/controlEncoder.sv
rtl/controlUnit.sv
dv/controlUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module controlUnitTb -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
  exit 0
fi
exit 1
